//--- common/fpuPkg.sv
////////////////////////////////////////////////////////////
// Binary32 only. No NaN-boxing and no dynamic rounding
// The divider truncates and flushes subnormals to zero
////////////////////////////////////////////////////////////
`default_nettype none

package fpuPkg;

  ////////////////////////////////////////////////////////////
  // Format and interface widths

  localparam int NumExp    = 8;    // Exponent field
  localparam int NumFrac   = 23;   // Fraction field, hidden bit not stored
  localparam int ExpBias   = 127;
  localparam int FlagWidth = 5;    // NV DZ OF UF NX, as in fflags
  localparam int TagWidth  = 4;    // Issuer tag, returned with the result
  localparam int DivCycles = 26;   // One quotient bit per clock, NumFrac + 3

  localparam logic [6:0]  OpFpOpcode   = 7'b1010011;  // OP-FP major opcode
  localparam logic [1:0]  FormatSingle = 2'b00;
  localparam logic [31:0] CanonNaN     = 32'h7fc00000;

  // Kept operations after decode
  typedef enum logic [2:0] {
    OpSgnj,      // fsgnj, fsgnjn, fsgnjx
    OpMinMax,    // fmin, fmax
    OpCmp,       // feq, flt, fle
    OpClass,     // fclass
    OpMove,      // fmv.x.w
    OpDiv        // fdiv.s
  } fpOpE;

  typedef struct packed {
    logic               sign;
    logic [NumExp-1:0]  exp;
    logic [NumFrac-1:0] frac;
  } fpFieldsT;

  // Raw bits for sign injection and move, fields for unpack
  typedef union packed {
    logic [31:0] raw;
    fpFieldsT    fields;
  } fpWordU;

  // Per-operand classification, exponent kept for the divider
  typedef struct packed {
    logic               zero;
    logic               inf;
    logic               nan;
    logic               snan;
    logic               normal;
    logic               subnormal;
    logic               sign;
    logic [NumExp-1:0]  exp;
    logic [NumFrac:0]   mant;       // Hidden bit restored, zero unless normal
  } fpClassT;

  typedef struct packed {
    fpOpE                op;
    logic [2:0]          funct3;    // Sub-select within the operation
    logic [TagWidth-1:0] tag;
  } fpCtrlT;

  typedef struct packed {
    logic                 valid;
    logic [31:0]          value;
    logic [FlagWidth-1:0] flags;
    logic [TagWidth-1:0]  tag;
  } fpResultT;

endpackage

`default_nettype wire

//--- fdiv/fpDivider.sv
////////////////////////////////////////////////////////////
// Restoring divider, truncating; DivCycles must be NumFrac+3
// Result is held until granted, one divide in flight
////////////////////////////////////////////////////////////
`default_nettype none

module fpDivider #(
  parameter int DivCycles = fpuPkg::DivCycles
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             reqValid,
  input  fpuPkg::fpCtrlT   ctrl,
  input  fpuPkg::fpClassT  aClass,
  input  fpuPkg::fpClassT  bClass,
  input  logic             divGrant,
  output fpuPkg::fpResultT divRes,
  output logic             DivBusy
);

  localparam int MantWidth  = fpuPkg::NumFrac + 1;
  localparam int CountWidth = $clog2(DivCycles);
  localparam int ExpWidth   = fpuPkg::NumExp + 2;   // Signed, room for over and under range

  typedef enum logic [1:0] {DivIdle, DivRun, DivNorm, DivHold} divStateE;

  divStateE                    state;
  logic                        start;
  logic [CountWidth-1:0]       count;
  logic [DivCycles-1:0]        quot;
  logic [MantWidth:0]          rem;           // Partial remainder, below twice the divisor
  logic [MantWidth-1:0]        divisor;
  logic                        geq;
  logic [MantWidth:0]          remNext;
  logic signed [ExpWidth-1:0]  expQ;          // Biased exponent for a quotient in [1,2)
  logic signed [ExpWidth-1:0]  expRes;
  logic                        sign;
  logic                        special;
  logic [31:0]                 specialVal;
  logic [fpuPkg::FlagWidth-1:0] specialFlags;
  logic                        spcNow;
  logic [31:0]                 spcVal;
  logic [fpuPkg::FlagWidth-1:0] spcFlags;
  logic                        aZero;
  logic                        bZero;
  logic                        hiBit;
  logic [MantWidth-1:0]        mant;
  logic                        inexact;
  logic                        ovf;
  logic                        unf;
  logic [31:0]                 normVal;

  assign start   = reqValid & (ctrl.op == fpuPkg::OpDiv) & (state == DivIdle);
  assign DivBusy = (state != DivIdle);
  assign aZero   = aClass.zero | aClass.subnormal;   // Subnormal inputs count as zero
  assign bZero   = bClass.zero | bClass.subnormal;

  ////////////////////////////////////////////////////////////
  // Special operands, settled at acceptance

  always_comb begin
    spcNow   = 1'b1;
    spcVal   = {aClass.sign ^ bClass.sign, 31'b0};
    spcFlags = '0;                                                  // {NV, DZ, OF, UF, NX}
    if (aClass.nan | bClass.nan) begin
      spcVal      = fpuPkg::CanonNaN;
      spcFlags[4] = aClass.snan | bClass.snan;
    end else if ((aZero & bZero) | (aClass.inf & bClass.inf)) begin
      spcVal      = fpuPkg::CanonNaN;
      spcFlags[4] = 1'b1;
    end else if (aClass.inf | bZero) begin
      spcVal      = {aClass.sign ^ bClass.sign, 8'hff, 23'b0};
      spcFlags[3] = bZero & ~aClass.inf;                            // Finite over zero
    end else if (!(aZero | bClass.inf)) begin
      spcNow = 1'b0;                                                // Ordinary divide
    end
  end

  // One restoring step
  assign geq     = (rem >= {1'b0, divisor});
  assign remNext = geq ? rem - {1'b0, divisor} : rem;

  ////////////////////////////////////////////////////////////
  // Normalise and truncate

  assign hiBit   = quot[DivCycles-1];                               // Quotient at least one
  assign mant    = hiBit ? quot[DivCycles-1 -: MantWidth] : quot[DivCycles-2 -: MantWidth];
  assign inexact = (|rem) | quot[0] | (hiBit & quot[DivCycles-MantWidth-1]);
  assign expRes  = hiBit ? expQ : expQ - 1;
  assign ovf     = (expRes >= 255);
  assign unf     = (expRes <= 0);                                   // Subnormal flushes to zero
  assign normVal = ovf ? {sign, 8'hfe, 23'h7fffff} :                // Largest finite
                   unf ? {sign, 31'b0} : {sign, expRes[7:0], mant[MantWidth-2:0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= DivIdle;
      divRes.valid <= 1'b0;
    end else begin
      case (state)
        DivIdle: if (start) begin
          state        <= DivRun;
          count        <= '0;
          quot         <= '0;
          rem          <= {1'b0, aClass.mant};
          divisor      <= bClass.mant;
          expQ         <= $signed({2'b0, aClass.exp}) - $signed({2'b0, bClass.exp})
                          + ExpWidth'(fpuPkg::ExpBias);
          sign         <= aClass.sign ^ bClass.sign;
          special      <= spcNow;
          specialVal   <= spcVal;
          specialFlags <= spcFlags;
          divRes.tag   <= ctrl.tag;
        end
        DivRun: begin
          quot  <= {quot[DivCycles-2:0], geq};
          rem   <= {remNext[MantWidth-1:0], 1'b0};
          count <= count + 1'b1;
          if (count == CountWidth'(DivCycles-1)) state <= DivNorm;
        end
        DivNorm: begin
          divRes.valid <= 1'b1;                                     // Offer to the arbiter
          divRes.value <= special ? specialVal : normVal;
          divRes.flags <= special ? specialFlags : {2'b0, ovf, unf, ovf | unf | inexact};
          state        <= DivHold;
        end
        default: if (divGrant) begin                                // DivHold
          divRes.valid <= 1'b0;
          state        <= DivIdle;
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    reqValid && ctrl.op == fpuPkg::OpDiv |-> !DivBusy)
    else $error("divide issued while divider busy");

  // Offer register loads DivCycles+1 clocks after the accepting edge
  assert property (@(posedge clk) disable iff (reset) start |=> ##(DivCycles+1) divRes.valid)
    else $error("divide offer late");

endmodule

`default_nettype wire

//--- hw/fpQuickOps.sv
////////////////////////////////////////////////////////////
// One register stage; compares use exact raw ordering
////////////////////////////////////////////////////////////
`default_nettype none

module fpQuickOps (
  input  logic             clk,
  input  logic             reset,
  input  logic             reqValid,
  input  fpuPkg::fpCtrlT   ctrl,
  input  fpuPkg::fpWordU   A,
  input  fpuPkg::fpWordU   B,
  input  fpuPkg::fpClassT  aClass,
  input  fpuPkg::fpClassT  bClass,
  output fpuPkg::fpResultT quickRes
);

  logic             bothZero;
  logic             anyNaN;
  logic             anySNaN;
  logic             orderLt;     // A below B, -0 below +0
  logic             lt;
  logic             eq;
  logic             sgnBit;
  logic             cmpBit;
  logic             cmpNV;
  logic [31:0]      minMaxVal;
  logic [9:0]       classMask;
  fpuPkg::fpResultT next;

  assign bothZero = ~|A.raw[30:0] & ~|B.raw[30:0];
  assign anyNaN   = aClass.nan | bClass.nan;
  assign anySNaN  = aClass.snan | bClass.snan;

  // Sign-magnitude ordering, reversed when both are negative
  assign orderLt = (A.raw[31] != B.raw[31]) ? A.raw[31] :
                   A.raw[31] ? (A.raw[30:0] > B.raw[30:0]) : (A.raw[30:0] < B.raw[30:0]);
  assign lt      = orderLt & ~bothZero;           // IEEE treats +0 and -0 as equal
  assign eq      = (A.raw == B.raw) | bothZero;

  ////////////////////////////////////////////////////////////
  // Per-operation results

  assign sgnBit = (ctrl.funct3[1:0] == 2'b00) ? B.raw[31] :       // fsgnj
                  (ctrl.funct3[1:0] == 2'b01) ? ~B.raw[31] :      // fsgnjn
                  A.raw[31] ^ B.raw[31];                          // fsgnjx

  always_comb begin
    if (aClass.nan & bClass.nan) begin
      minMaxVal = fpuPkg::CanonNaN;
    end else if (aClass.nan) begin
      minMaxVal = B.raw;
    end else if (bClass.nan) begin
      minMaxVal = A.raw;
    end else begin
      minMaxVal = (orderLt ^ ctrl.funct3[0]) ? A.raw : B.raw;    // funct3 0 min, 1 max
    end
  end

  assign cmpBit = ~anyNaN & ((ctrl.funct3 == 3'd2) ? eq :
                             (ctrl.funct3 == 3'd1) ? lt : (lt | eq));
  assign cmpNV  = (ctrl.funct3 == 3'd2) ? anySNaN : anyNaN;       // Quiet NaN only traps flt/fle

  assign classMask = {aClass.nan & ~aClass.snan, aClass.snan,
                      ~aClass.sign & aClass.inf, ~aClass.sign & aClass.normal,
                      ~aClass.sign & aClass.subnormal, ~aClass.sign & aClass.zero,
                      aClass.sign & aClass.zero, aClass.sign & aClass.subnormal,
                      aClass.sign & aClass.normal, aClass.sign & aClass.inf};

  always_comb begin
    next.valid = reqValid & (ctrl.op != fpuPkg::OpDiv);   // Divides go to the peer
    next.tag   = ctrl.tag;
    next.flags = '0;
    case (ctrl.op)
      fpuPkg::OpSgnj:   next.value = {sgnBit, A.raw[30:0]};
      fpuPkg::OpMinMax: begin
        next.value = minMaxVal;
        next.flags = {anySNaN, {(fpuPkg::FlagWidth-1){1'b0}}};
      end
      fpuPkg::OpCmp: begin
        next.value = {31'b0, cmpBit};
        next.flags = {cmpNV, {(fpuPkg::FlagWidth-1){1'b0}}};
      end
      fpuPkg::OpClass:  next.value = {22'b0, classMask};
      default:          next.value = A.raw;               // fmv.x.w
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      quickRes.valid <= 1'b0;
    end else begin
      quickRes <= next;
    end
  end

endmodule

`default_nettype wire

//--- hw/fpUnpack.sv
////////////////////////////////////////////////////////////
// Subnormals are flagged but carry a zero significand
////////////////////////////////////////////////////////////
`default_nettype none

module fpUnpack (
  input  fpuPkg::fpWordU  A,
  input  fpuPkg::fpWordU  B,
  output fpuPkg::fpClassT aClass,
  output fpuPkg::fpClassT bClass
);

  function automatic fpuPkg::fpClassT classify(input fpuPkg::fpWordU w);
    fpuPkg::fpClassT c;
    logic            expZero;
    logic            expMax;
    logic            fracZero;
    expZero     = (w.fields.exp == '0);
    expMax      = &w.fields.exp;
    fracZero    = (w.fields.frac == '0);
    c.sign      = w.fields.sign;
    c.exp       = w.fields.exp;
    c.zero      = expZero & fracZero;
    c.subnormal = expZero & ~fracZero;
    c.inf       = expMax & fracZero;
    c.nan       = expMax & ~fracZero;
    c.snan      = c.nan & ~w.fields.frac[fpuPkg::NumFrac-1];  // Quiet bit clear
    c.normal    = ~expZero & ~expMax;
    c.mant      = c.normal ? {1'b1, w.fields.frac} : '0;
    return c;
  endfunction

  assign aClass = classify(A);
  assign bClass = classify(B);

endmodule

`default_nettype wire

//--- hw/fpuDecode.sv
////////////////////////////////////////////////////////////
// Combinational decode. Divide accepts the static rm codes
// but always truncates; dynamic rm (111) is illegal
////////////////////////////////////////////////////////////
`default_nettype none

module fpuDecode (
  input  logic                        clk,
  input  logic                        UpValid,
  input  logic [4:0]                  Operation,     // funct5
  input  logic [1:0]                  Format,
  input  logic [2:0]                  Funct3,
  input  logic [6:0]                  Opcode,
  input  logic [fpuPkg::TagWidth-1:0] Tag,
  output logic                        reqValid,
  output fpuPkg::fpCtrlT              ctrl,
  output logic                        IllegalInstr
);

  fpuPkg::fpOpE op;
  logic         known;   // funct5/Funct3 pair names a kept operation
  logic         legal;

  always_comb begin
    op    = fpuPkg::OpSgnj;
    known = 1'b1;
    case (Operation)
      5'b00100: known = (Funct3 <= 3'd2);     // fsgnj, fsgnjn, fsgnjx
      5'b00101: begin
        op    = fpuPkg::OpMinMax;
        known = (Funct3 <= 3'd1);             // fmin, fmax
      end
      5'b10100: begin
        op    = fpuPkg::OpCmp;
        known = (Funct3 <= 3'd2);             // fle, flt, feq
      end
      5'b11100: begin
        op    = Funct3[0] ? fpuPkg::OpClass : fpuPkg::OpMove;
        known = (Funct3 <= 3'd1);
      end
      5'b00011: begin
        op    = fpuPkg::OpDiv;
        known = (Funct3 <= 3'd4);             // Static rounding modes only
      end
      default: known = 1'b0;
    endcase
  end

  assign legal        = known & (Opcode == fpuPkg::OpFpOpcode) & (Format == fpuPkg::FormatSingle);
  assign reqValid     = UpValid & legal;
  assign IllegalInstr = UpValid & ~legal;       // Request is dropped
  assign ctrl         = '{op: op, funct3: Funct3, tag: Tag};

  // Flagged requests never reach the execution peers
  assert property (@(posedge clk) IllegalInstr |-> UpValid && !reqValid)
    else $error("illegal request forwarded or raised without a strobe");

endmodule

`default_nettype wire

//--- hw/fpuTop.sv
////////////////////////////////////////////////////////////
// Strobe interface, no back-pressure except DivBusy
// Results may return out of issue order, match on tag
////////////////////////////////////////////////////////////
`default_nettype none

module fpuTop #(
  parameter int DivCycles = fpuPkg::DivCycles
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         UpValid,
  input  logic [4:0]                   Operation,
  input  logic [1:0]                   Format,
  input  logic [2:0]                   Funct3,
  input  logic [6:0]                   Opcode,
  input  logic [fpuPkg::TagWidth-1:0]  Tag,
  input  fpuPkg::fpWordU               A,
  input  fpuPkg::fpWordU               B,
  output logic [31:0]                  Res,
  output logic [fpuPkg::FlagWidth-1:0] Flags,
  output logic [fpuPkg::TagWidth-1:0]  ResultTag,
  output logic                         DownValid,
  output logic                         DivBusy,
  output logic                         IllegalInstr
);

  logic             reqValid;
  fpuPkg::fpCtrlT   ctrl;
  fpuPkg::fpClassT  aClass;
  fpuPkg::fpClassT  bClass;
  fpuPkg::fpResultT quickRes;
  fpuPkg::fpResultT divRes;
  logic             divGrant;

  fpuDecode decode (.clk, .UpValid, .Operation, .Format, .Funct3, .Opcode, .Tag,
                    .reqValid, .ctrl, .IllegalInstr);

  fpUnpack unpack (.A, .B, .aClass, .bClass);

  fpQuickOps quickOps (.clk, .reset, .reqValid, .ctrl, .A, .B, .aClass, .bClass, .quickRes);

  fpDivider #(.DivCycles(DivCycles)) divider (.clk, .reset, .reqValid, .ctrl, .aClass, .bClass,
                                             .divGrant, .divRes, .DivBusy);

  // Single result port
  resultArbiter arbiter (.clk, .reset, .quickRes, .divRes, .divGrant,
                         .Res, .Flags, .ResultTag, .DownValid);

endmodule

`default_nettype wire

//--- hw/resultArbiter.sv
////////////////////////////////////////////////////////////
// Quick pipeline always wins; the divider waits its turn
////////////////////////////////////////////////////////////
`default_nettype none

module resultArbiter (
  input  logic                         clk,
  input  logic                         reset,
  input  fpuPkg::fpResultT             quickRes,
  input  fpuPkg::fpResultT             divRes,
  output logic                         divGrant,
  output logic [31:0]                  Res,
  output logic [fpuPkg::FlagWidth-1:0] Flags,
  output logic [fpuPkg::TagWidth-1:0]  ResultTag,
  output logic                         DownValid
);

  fpuPkg::fpResultT winner;

  assign divGrant = divRes.valid & ~quickRes.valid;   // Only on an idle quick slot
  assign winner   = quickRes.valid ? quickRes : divRes;

  always_ff @(posedge clk) begin
    if (reset) begin
      DownValid <= 1'b0;
    end else begin
      DownValid <= quickRes.valid | divRes.valid;
    end
  end

  // Output payload register
  always_ff @(posedge clk) begin
    Res       <= winner.value;
    Flags     <= winner.flags;
    ResultTag <= winner.tag;
  end

  // A granted divide owns the next output slot
  assert property (@(posedge clk) disable iff (reset)
    divGrant |-> !quickRes.valid ##1 (DownValid && ResultTag == $past(divRes.tag)))
    else $error("divide granted over a quick result or lost");

endmodule

`default_nettype wire

//--- sources.f
common/fpuPkg.sv
hw/fpuDecode.sv
hw/fpUnpack.sv
hw/fpQuickOps.sv
fdiv/fpDivider.sv
hw/resultArbiter.sv
hw/fpuTop.sv
tb/fpuTb.sv

//--- tb/fpuTb.sv
////////////////////////////////////////////////////////////
// Random quick operations from a fixed-seed LCG. Divides use
// chosen operands with exact or hand-derived quotients
////////////////////////////////////////////////////////////
`default_nettype none

module fpuTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int         Timeout   = 4 * fpuPkg::DivCycles;   // Cycles allowed per wait loop
  localparam int         NumTags   = 1 << fpuPkg::TagWidth;
  localparam logic [4:0] DivFunct5 = 5'b00011;
  localparam logic [4:0] FlagNV    = 5'b10000;                // fflags order NV DZ OF UF NX
  localparam logic [4:0] FlagDZ    = 5'b01000;
  localparam logic [4:0] FlagOF    = 5'b00100;
  localparam logic [4:0] FlagUF    = 5'b00010;
  localparam logic [4:0] FlagNX    = 5'b00001;

  logic                         clk;
  logic                         reset;
  logic                         UpValid;
  logic [4:0]                   Operation;
  logic [1:0]                   Format;
  logic [2:0]                   Funct3;
  logic [6:0]                   Opcode;
  logic [fpuPkg::TagWidth-1:0]  Tag;
  fpuPkg::fpWordU               A;
  fpuPkg::fpWordU               B;
  logic [31:0]                  Res;
  logic [fpuPkg::FlagWidth-1:0] Flags;
  logic [fpuPkg::TagWidth-1:0]  ResultTag;
  logic                         DownValid;
  logic                         DivBusy;
  logic                         IllegalInstr;

  // Scoreboard, one entry per tag
  fpuPkg::fpResultT expTable [NumTags];
  string            expName  [NumTags];
  int               issCount [NumTags] = '{default: 0};
  int               retCount [NumTags] = '{default: 0};
  int               nextTag;
  logic             expectIllegal;      // Driven with each strobe
  logic             strobeSeen;
  logic [31:0]      rngState;

  fpuTop #(.DivCycles(fpuPkg::DivCycles)) UUT (
    .clk, .reset, .UpValid, .Operation, .Format, .Funct3, .Opcode, .Tag, .A, .B,
    .Res, .Flags, .ResultTag, .DownValid, .DivBusy, .IllegalInstr
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;             // 20 ns period
  end

  always @(posedge clk) begin
    if (!reset && DownValid) retCount[ResultTag] <= retCount[ResultTag] + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  function automatic logic [31:0] orderKey(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};   // Monotonic in value, -0 just below +0
  endfunction

  function automatic logic isNaN(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic isSNaN(input logic [31:0] x);
    return isNaN(x) && !x[22];
  endfunction

  function automatic logic [9:0] classOf(input logic [31:0] x);
    int bitPos;
    if (isNaN(x)) bitPos = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hff) bitPos = x[31] ? 0 : 7;
    else if (x[30:0] == 31'd0) bitPos = x[31] ? 3 : 4;
    else if (x[30:23] == 8'h00) bitPos = x[31] ? 2 : 5;   // Subnormal
    else bitPos = x[31] ? 1 : 6;
    return 10'b1 << bitPos;
  endfunction

  function automatic fpuPkg::fpResultT makeExpected(input logic [31:0] v, input logic [4:0] f);
    fpuPkg::fpResultT r;
    r       = '0;
    r.valid = 1'b1;
    r.value = v;
    r.flags = f;
    return r;
  endfunction

  // Kind 0 sign injection, 1 min/max, 2 compare, 3 classify, 4 move
  function automatic fpuPkg::fpResultT quickRef(input int kind, input logic [2:0] f3,
                                                input logic [31:0] a, input logic [31:0] b);
    logic [31:0] v;
    logic [4:0]  f;
    logic        anyNaN;
    logic        eq;
    logic        lt;
    f      = 5'b0;
    anyNaN = isNaN(a) || isNaN(b);
    eq     = (a == b) || (a[30:0] == 31'd0 && b[30:0] == 31'd0);
    lt     = !eq && (orderKey(a) < orderKey(b));
    case (kind)
      0: v = {(f3 == 3'd0) ? b[31] : (f3 == 3'd1) ? !b[31] : a[31] ^ b[31], a[30:0]};
      1: begin
        if (isNaN(a) && isNaN(b)) v = 32'h7fc00000;
        else if (isNaN(a)) v = b;
        else if (isNaN(b)) v = a;
        else v = ((orderKey(a) < orderKey(b)) == (f3 == 3'd0)) ? a : b;
        if (isSNaN(a) || isSNaN(b)) f = FlagNV;
      end
      2: begin
        v = {31'b0, !anyNaN && ((f3 == 3'd2) ? eq : (f3 == 3'd1) ? lt : (lt || eq))};
        if ((f3 == 3'd2) ? (isSNaN(a) || isSNaN(b)) : anyNaN) f = FlagNV;
      end
      3: v = {22'b0, classOf(a)};
      default: v = a;
    endcase
    return makeExpected(v, f);
  endfunction

  function automatic logic [4:0] funct5Of(input int kind);
    case (kind)
      0: return 5'b00100;
      1: return 5'b00101;
      2: return 5'b10100;
      default: return 5'b11100;         // fclass and fmv.x.w
    endcase
  endfunction

  function automatic logic [2:0] pickFunct3(input int kind);
    case (kind)
      0, 2: return 3'((nextRandom() >> 12) % 3);
      1: return 3'((nextRandom() >> 12) % 2);
      3: return 3'd1;
      default: return 3'd0;
    endcase
  endfunction

  function automatic logic [31:0] pickOperand();
    logic [31:0] r;
    r = nextRandom();
    if (r[31:30] != 2'b00) return nextRandom();   // Mostly plain random words
    case ((r >> 16) % 10)
      0: return 32'h00000000;
      1: return 32'h80000000;
      2: return 32'h7f800000;
      3: return 32'hff800000;
      4: return 32'h7fc00000;           // Quiet NaN
      5: return 32'h7f800001;           // Signalling NaN
      6: return 32'h00000001;
      7: return 32'h80400000;
      8: return 32'h3f800000;
      default: return 32'hbf800000;
    endcase
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NumTags; i++) n += issCount[i] - retCount[i];
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic takeTag(output int t);
    int tries;
    tries = 0;
    t     = nextTag;
    while (issCount[t] != retCount[t]) begin
      if (tries >= NumTags) abortRun("no free tag for a new request");
      t = (t + 1) % NumTags;
      tries++;
    end
    nextTag = (t + 1) % NumTags;
  endtask

  task automatic drive(input string name, input logic [4:0] f5, input logic [2:0] f3,
                       input logic [31:0] a, input logic [31:0] b,
                       input fpuPkg::fpResultT expRes);
    int t;
    @(posedge clk);
    takeTag(t);
    UpValid       <= 1'b1;
    Operation     <= f5;
    Format        <= fpuPkg::FormatSingle;
    Funct3        <= f3;
    Opcode        <= fpuPkg::OpFpOpcode;
    Tag           <= t[fpuPkg::TagWidth-1:0];
    A.raw         <= a;
    B.raw         <= b;
    expectIllegal <= 1'b0;
    strobeSeen    <= 1'b1;
    expTable[t]   <= expRes;
    expName[t]    <= name;
    issCount[t]   <= issCount[t] + 1;
  endtask

  task automatic issueQuick(input string name, input int kind, input logic [2:0] f3,
                            input logic [31:0] a, input logic [31:0] b);
    drive(name, funct5Of(kind), f3, a, b, quickRef(kind, f3, a, b));
  endtask

  task automatic issueIllegal(input logic [6:0] opc, input logic [1:0] fmt,
                              input logic [4:0] f5, input logic [2:0] f3);
    int t;
    @(posedge clk);
    takeTag(t);                         // Fresh tag, never counted as issued
    UpValid       <= 1'b1;
    Operation     <= f5;
    Format        <= fmt;
    Funct3        <= f3;
    Opcode        <= opc;
    Tag           <= t[fpuPkg::TagWidth-1:0];
    expectIllegal <= 1'b1;
    strobeSeen    <= 1'b1;
  endtask

  task automatic idle();
    @(posedge clk);
    UpValid       <= 1'b0;
    expectIllegal <= 1'b0;
  endtask

  task automatic drain(input string what);
    int waited;
    waited = 0;
    while (outstanding() != 0) begin
      if (waited >= Timeout) abortRun($sformatf("timeout waiting for %s results", what));
      @(posedge clk);
      waited++;
    end
  endtask

  task automatic waitNotBusy();
    int waited;
    waited = 0;
    while (DivBusy) begin
      if (waited >= Timeout) abortRun("timeout waiting for the divider to go idle");
      @(posedge clk);
      waited++;
    end
  endtask

  task automatic runDivide(input string name, input logic [31:0] a, input logic [31:0] b,
                           input fpuPkg::fpResultT expRes);
    waitNotBusy();
    drive(name, DivFunct5, 3'b001, a, b, expRes);   // RTZ
    idle();
    drain(name);
  endtask

  ////////////////////////////////////////////////////////////
  // Checks

  assert property (@(posedge clk) disable iff (reset)
    !strobeSeen |-> !DownValid && !DivBusy && !IllegalInstr)
    else abortRun("an output went high after reset before the first strobe");

  assert property (@(posedge clk) disable iff (reset)
    UpValid && !expectIllegal && Operation != DivFunct5
      |-> ##2 (DownValid && ResultTag == $past(Tag, 2)))
    else abortRun("a quick result did not leave two clocks after its strobe");

  assert property (@(posedge clk) disable iff (reset)
    IllegalInstr == (UpValid && expectIllegal))
    else abortRun($sformatf("FAIL illegal decode: expected %b actual %b",
                            $sampled(UpValid) & $sampled(expectIllegal),
                            $sampled(IllegalInstr)));

  // Catches unknown tags and second returns
  assert property (@(posedge clk) disable iff (reset)
    DownValid |-> issCount[ResultTag] != retCount[ResultTag])
    else abortRun($sformatf("result tag %0d was never issued or came back twice",
                            $sampled(ResultTag)));

  assert property (@(posedge clk) disable iff (reset)
    DownValid |-> Res == expTable[ResultTag].value)
    else abortRun($sformatf("FAIL %s value: expected %h actual %h",
                            expName[$sampled(ResultTag)],
                            expTable[$sampled(ResultTag)].value, $sampled(Res)));

  assert property (@(posedge clk) disable iff (reset)
    DownValid |-> Flags == expTable[ResultTag].flags)
    else abortRun($sformatf("FAIL %s flags: expected %b actual %b",
                            expName[$sampled(ResultTag)],
                            expTable[$sampled(ResultTag)].flags, $sampled(Flags)));

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int         kind;
    logic [2:0] f3;
    reset         = 1'b1;
    UpValid       = 1'b0;
    Operation     = '0;
    Format        = '0;
    Funct3        = '0;
    Opcode        = '0;
    Tag           = '0;
    A             = '0;
    B             = '0;
    expectIllegal = 1'b0;
    strobeSeen    = 1'b0;
    nextTag       = 0;
    rngState      = 32'd69530;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (4) idle();                  // Quiet window after reset

    issueQuick("fsgnj", 0, 3'd0, 32'h3f800000, 32'hc0000000);
    issueQuick("fsgnjn", 0, 3'd1, 32'hbf800000, 32'hc0000000);
    issueQuick("fsgnjx", 0, 3'd2, 32'hbf800000, 32'hc0000000);
    issueQuick("fmin zeros", 1, 3'd0, 32'h00000000, 32'h80000000);
    issueQuick("fmax zeros", 1, 3'd1, 32'h80000000, 32'h00000000);
    issueQuick("fmin one nan", 1, 3'd0, 32'h7fc00000, 32'h40400000);
    issueQuick("fmax two nan", 1, 3'd1, 32'h7f800001, 32'h7fc00000);
    issueQuick("feq snan", 2, 3'd2, 32'h7f800001, 32'h3f800000);
    issueQuick("feq qnan", 2, 3'd2, 32'h7fc00000, 32'h3f800000);
    issueQuick("flt qnan", 2, 3'd1, 32'h3f800000, 32'h7fc00000);
    issueQuick("fle zeros", 2, 3'd0, 32'h80000000, 32'h00000000);
    issueQuick("flt zeros", 2, 3'd1, 32'h80000000, 32'h00000000);
    issueQuick("fclass", 3, 3'd1, 32'h00400000, 32'h00000000);
    issueQuick("fmv.x.w", 4, 3'd0, 32'hdeadbeef, 32'h00000000);
    for (int i = 0; i < 80; i++) begin
      kind = int'((nextRandom() >> 8) % 5);
      f3   = pickFunct3(kind);
      issueQuick("random quick", kind, f3, pickOperand(), pickOperand());
    end
    idle();
    drain("quick");

    // Exact, power of two, truncated
    runDivide("fdiv 6/3", 32'h40c00000, 32'h40400000, makeExpected(32'h40000000, 5'b0));
    runDivide("fdiv 5/0.25", 32'h40a00000, 32'h3e800000, makeExpected(32'h41a00000, 5'b0));
    runDivide("fdiv -7.5/2", 32'hc0f00000, 32'h40000000, makeExpected(32'hc0700000, 5'b0));
    runDivide("fdiv 1/3", 32'h3f800000, 32'h40400000, makeExpected(32'h3eaaaaaa, FlagNX));
    // Special operands
    runDivide("fdiv 1/0", 32'h3f800000, 32'h00000000, makeExpected(32'h7f800000, FlagDZ));
    runDivide("fdiv -1/0", 32'hbf800000, 32'h00000000, makeExpected(32'hff800000, FlagDZ));
    runDivide("fdiv 0/0", 32'h00000000, 32'h80000000, makeExpected(32'h7fc00000, FlagNV));
    runDivide("fdiv inf/inf", 32'h7f800000, 32'hff800000, makeExpected(32'h7fc00000, FlagNV));
    runDivide("fdiv qnan", 32'h7fc00001, 32'h3f800000, makeExpected(32'h7fc00000, 5'b0));
    runDivide("fdiv snan", 32'h3f800000, 32'h7f800001, makeExpected(32'h7fc00000, FlagNV));
    runDivide("fdiv -inf/2", 32'hff800000, 32'h40000000, makeExpected(32'hff800000, 5'b0));
    runDivide("fdiv -0/5", 32'h80000000, 32'h40a00000, makeExpected(32'h80000000, 5'b0));
    runDivide("fdiv 3/inf", 32'h40400000, 32'h7f800000, makeExpected(32'h00000000, 5'b0));
    runDivide("fdiv overflow", 32'h7f000000, 32'h3e800000,
              makeExpected(32'h7f7fffff, FlagOF | FlagNX));
    runDivide("fdiv underflow", 32'h80800000, 32'h40000000,
              makeExpected(32'h80000000, FlagUF | FlagNX));

    // Back-to-back quick ops keep the result port busy past the divide offer
    waitNotBusy();
    drive("fdiv under load", DivFunct5, 3'b001, 32'h3f800000, 32'h40400000,
          makeExpected(32'h3eaaaaaa, FlagNX));
    for (int i = 0; i < 40; i++) begin
      kind = int'((nextRandom() >> 8) % 5);
      f3   = pickFunct3(kind);
      issueQuick("quick under load", kind, f3, pickOperand(), pickOperand());
    end
    idle();
    drain("load");

    issueIllegal(7'b0000111, fpuPkg::FormatSingle, 5'b00100, 3'd0);   // Wrong opcode
    idle();
    issueIllegal(fpuPkg::OpFpOpcode, 2'b01, 5'b00100, 3'd0);          // Double format
    idle();
    issueIllegal(fpuPkg::OpFpOpcode, fpuPkg::FormatSingle, 5'b01111, 3'd0);
    idle();
    issueIllegal(fpuPkg::OpFpOpcode, fpuPkg::FormatSingle, 5'b00100, 3'd3);
    idle();
    repeat (4) idle();
    drain("illegal");

    if (outstanding() != 0) begin
      abortRun("results still outstanding at the end of the run");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
